// ==== include/afu_consts.svh ====
/*
  Widths, register word addresses and identifier values of the function unit.
  Register addresses are word addresses as seen on the host link.
  The identifier values are fixed and read-only.
*/
`ifndef AFU_CONSTS_SVH
`define AFU_CONSTS_SVH

// ==================================================
// Bus widths
// ==================================================
`define AFU_DATA_W 64
`define AFU_ADDR_W 16
`define AFU_TID_W 9
`define AFU_OP_W 2

// Flops in the soft reset chain
`define AFU_RST_SYNC_STAGES 3

// ==================================================
// Register map
// ==================================================
`define CSR_ID_L 16'h0002
`define CSR_ID_H 16'h0004
`define CSR_SCRATCH0 16'h0010
`define CSR_SCRATCH1 16'h0012
// Opcode sits in the low bits of the command word
`define CSR_CMD 16'h0014
`define CSR_RESULT 16'h0016
`define CSR_STATUS 16'h0018

// Identifier returned on ID_L and ID_H reads
`define AFU_ID_L 64'h9f3c_51a2_7e04_b6d1
`define AFU_ID_H 64'h4d2e_0c8b_a615_3f70

`endif

// ==== source/afu_pkg.sv ====
/*
  Shared types of the function unit.
  Opcodes wrap at the data width; no carry or overflow is reported.
*/
`include "afu_consts.svh"

package afu_pkg;

    // Command opcodes, taken from the low bits of the CMD word
    typedef enum logic [`AFU_OP_W-1:0]
    {
        // Result and count stay as they are
        OP_NOP = 2'd0,
        // Operand 0 plus operand 1
        OP_ADD = 2'd1,
        // Operand 0 minus operand 1
        OP_SUB = 2'd2,
        // Bitwise exclusive-or
        OP_XOR = 2'd3
    } t_csr_op;

    // MMIO request as it arrives on the host link
    typedef struct packed
    {
        logic                   wr;
        logic                   rd;
        logic [`AFU_ADDR_W-1:0] addr;
        logic [`AFU_TID_W-1:0]  tid;
        logic [`AFU_DATA_W-1:0] data;
    } t_mmio_req;

    // Read response, tag copied from the request
    typedef struct packed
    {
        logic                   valid;
        logic [`AFU_TID_W-1:0]  tid;
        logic [`AFU_DATA_W-1:0] data;
    } t_mmio_rsp;

endpackage

// ==== source/mmio_if.sv ====
/*
  MMIO request and response wires between the host-link edge and the
  register file, plus the synchronized reset. Strobes are single cycle and
  the response side has no flow control.
*/
`timescale 1ns/10ps
`include "afu_consts.svh"

interface mmio_if;

    // Request strobes, never both high
    logic                   req_wr;
    logic                   req_rd;
    // Request payload
    logic [`AFU_ADDR_W-1:0] req_addr;
    logic [`AFU_TID_W-1:0]  req_tid;
    logic [`AFU_DATA_W-1:0] req_data;

    // Read response, one per read
    logic                   rsp_valid;
    logic [`AFU_TID_W-1:0]  rsp_tid;
    logic [`AFU_DATA_W-1:0] rsp_data;

    // Reset after the synchronizer chain
    logic                   plif_reset;

    // Shell side drives requests and reset
    modport edge_side
    (
        output req_wr, req_rd, req_addr, req_tid, req_data, plif_reset,
        input  rsp_valid, rsp_tid, rsp_data
    );

    // Register file side answers reads
    modport csr
    (
        input  req_wr, req_rd, req_addr, req_tid, req_data, plif_reset,
        output rsp_valid, rsp_tid, rsp_data
    );

endinterface

// ==== source/csr_op_unit.sv ====
/*
  Operation unit behind the CMD register. A command strobe with a non-NOP
  opcode updates the result one cycle later and bumps the completion count.
  Arithmetic wraps at the data width.
*/
`timescale 1ns/10ps
`include "afu_consts.svh"

module csr_op_unit
(
    input  logic                   pClk,
    input  logic                   reset,
    // One-cycle command strobe and its opcode
    input  logic                   cmd_valid,
    input  afu_pkg::t_csr_op       cmd_op,
    // Operands as held in the scratch registers
    input  logic [`AFU_DATA_W-1:0] operand_a,
    input  logic [`AFU_DATA_W-1:0] operand_b,
    output logic [`AFU_DATA_W-1:0] result,
    output logic [`AFU_DATA_W-1:0] done_count
);

    logic [`AFU_DATA_W-1:0] op_value;
    logic                   op_fire;

    // NOP strobes are accepted but change nothing
    assign op_fire = cmd_valid && (cmd_op != afu_pkg::OP_NOP);

    always_comb
    begin
        case (cmd_op)
            afu_pkg::OP_ADD: op_value = operand_a + operand_b;
            afu_pkg::OP_SUB: op_value = operand_a - operand_b;
            afu_pkg::OP_XOR: op_value = operand_a ^ operand_b;
            // Hold on NOP
            default:         op_value = result;
        endcase
    end

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            result     <= '0;
            done_count <= '0;
        end
        else if (op_fire)
        begin
            result     <= op_value;
            done_count <= done_count + 1'b1;
        end
    end

    // Only a command may move the result
    a_result_stable: assert property (@(posedge pClk)
        !cmd_valid && !reset |=> $stable(result))
        else $error("csr_op_unit: result changed without a command");

endmodule

// ==== source/ccip_edge.sv ====
/*
  Host-link edge. Requests are registered once on the way in and responses
  once on the way out, so this block adds two cycles to a read.
  Everything runs on pClk; there is no clock crossing.
*/
`timescale 1ns/10ps
`include "afu_consts.svh"

module ccip_edge
(
    input  logic                   pClk,
    input  logic                   reset,

    // Host-link MMIO request
    input  logic                   rx_mmio_wr,
    input  logic                   rx_mmio_rd,
    input  logic [`AFU_ADDR_W-1:0] rx_mmio_addr,
    input  logic [`AFU_TID_W-1:0]  rx_mmio_tid,
    input  logic [`AFU_DATA_W-1:0] rx_mmio_data,

    // Host-link MMIO response
    output logic                   tx_rsp_valid,
    output logic [`AFU_TID_W-1:0]  tx_rsp_tid,
    output logic [`AFU_DATA_W-1:0] tx_rsp_data,

    mmio_if.edge_side              mmio
);

    // ==================================================
    // Soft reset synchronizer
    // ==================================================

    // Kept as separate flops so synthesis does not merge the chain
    (* preserve *) logic [`AFU_RST_SYNC_STAGES-1:0] rst_sync;

    always_ff @(posedge pClk)
    begin
        rst_sync <= {rst_sync[`AFU_RST_SYNC_STAGES-2:0], reset};
    end

    // Last stage is the reset seen by the user logic
    assign mmio.plif_reset = rst_sync[`AFU_RST_SYNC_STAGES-1];

    // ==================================================
    // Input register stage
    // ==================================================
    afu_pkg::t_mmio_req req_q;

    always_ff @(posedge pClk)
    begin
        // Payload is simply retimed
        req_q.addr <= rx_mmio_addr;
        req_q.tid  <= rx_mmio_tid;
        req_q.data <= rx_mmio_data;
        if (mmio.plif_reset)
        begin
            req_q.wr <= 1'b0;
            req_q.rd <= 1'b0;
        end
        else
        begin
            req_q.wr <= rx_mmio_wr;
            req_q.rd <= rx_mmio_rd;
        end
    end

    assign mmio.req_wr   = req_q.wr;
    assign mmio.req_rd   = req_q.rd;
    assign mmio.req_addr = req_q.addr;
    assign mmio.req_tid  = req_q.tid;
    assign mmio.req_data = req_q.data;

    // ==================================================
    // Output response register
    // ==================================================
    afu_pkg::t_mmio_rsp rsp_q;

    always_ff @(posedge pClk)
    begin
        rsp_q.tid  <= mmio.rsp_tid;
        rsp_q.data <= mmio.rsp_data;
        // Any stage of the chain holds valid low, so a read in flight
        // when reset arrives is dropped before plif_reset rises
        if (|rst_sync)
            rsp_q.valid <= 1'b0;
        else
            rsp_q.valid <= mmio.rsp_valid;
    end

    assign tx_rsp_valid = rsp_q.valid;
    assign tx_rsp_tid   = rsp_q.tid;
    assign tx_rsp_data  = rsp_q.data;

    // No response leaves the shell while the user logic is in reset
    a_no_rsp_in_reset: assert property (@(posedge pClk) mmio.plif_reset |-> !tx_rsp_valid)
        else $error("ccip_edge: response valid while plif_reset is high");

endmodule

// ==== source/mmio_csr_file.sv ====
/*
  MMIO register file. Reads answer one cycle after the request with the
  request tag; unmapped reads return zero. Writes to read-only or unmapped
  addresses are dropped. CMD writes reach the operation unit one cycle later.
*/
`timescale 1ns/10ps
`include "afu_consts.svh"

module mmio_csr_file
(
    input logic pClk,
    mmio_if.csr mmio
);

    // ==================================================
    // Register storage
    // ==================================================
    logic [`AFU_DATA_W-1:0] scratch0;
    logic [`AFU_DATA_W-1:0] scratch1;
    afu_pkg::t_csr_op       cmd_op_q;
    logic                   cmd_valid_q;
    logic [`AFU_DATA_W-1:0] result;
    logic [`AFU_DATA_W-1:0] done_count;

    // Write decode, only the writable words
    logic wr_scratch0;
    logic wr_scratch1;
    logic wr_cmd;

    assign wr_scratch0 = mmio.req_wr && (mmio.req_addr == `CSR_SCRATCH0);
    assign wr_scratch1 = mmio.req_wr && (mmio.req_addr == `CSR_SCRATCH1);
    assign wr_cmd      = mmio.req_wr && (mmio.req_addr == `CSR_CMD);

    always_ff @(posedge pClk)
    begin
        if (mmio.plif_reset)
        begin
            scratch0    <= '0;
            scratch1    <= '0;
            cmd_op_q    <= afu_pkg::OP_NOP;
            cmd_valid_q <= 1'b0;
        end
        else
        begin
            if (wr_scratch0)
                scratch0 <= mmio.req_data;
            if (wr_scratch1)
                scratch1 <= mmio.req_data;
            // Last opcode stays readable after the strobe
            if (wr_cmd)
                cmd_op_q <= afu_pkg::t_csr_op'(mmio.req_data[`AFU_OP_W-1:0]);
            cmd_valid_q <= wr_cmd;
        end
    end

    // Operands are the scratch values in the strobe cycle
    csr_op_unit u_op_unit
    (
        .pClk       (pClk),
        .reset      (mmio.plif_reset),
        .cmd_valid  (cmd_valid_q),
        .cmd_op     (cmd_op_q),
        .operand_a  (scratch0),
        .operand_b  (scratch1),
        .result     (result),
        .done_count (done_count)
    );

    // ==================================================
    // Read path
    // ==================================================
    logic [`AFU_DATA_W-1:0] rd_data;

    always_comb
    begin
        case (mmio.req_addr)
            `CSR_ID_L:     rd_data = `AFU_ID_L;
            `CSR_ID_H:     rd_data = `AFU_ID_H;
            `CSR_SCRATCH0: rd_data = scratch0;
            `CSR_SCRATCH1: rd_data = scratch1;
            `CSR_CMD:      rd_data = {{(`AFU_DATA_W-`AFU_OP_W){1'b0}}, cmd_op_q};
            `CSR_RESULT:   rd_data = result;
            `CSR_STATUS:   rd_data = done_count;
            // Holes in the map read as zero
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge pClk)
    begin
        mmio.rsp_tid  <= mmio.req_tid;
        mmio.rsp_data <= rd_data;
        if (mmio.plif_reset)
            mmio.rsp_valid <= 1'b0;
        else
            mmio.rsp_valid <= mmio.req_rd;
    end

    // The host link never issues a read and a write in the same cycle
    a_no_rd_wr_overlap: assert property (@(posedge pClk) !(mmio.req_wr && mmio.req_rd))
        else $error("mmio_csr_file: read and write strobes high together");

endmodule

// ==== source/afu_top.sv ====
/*
  Top of the function unit with plain host-link ports.
  A read sampled at the inputs answers three clocks later; writes give
  no response. Reset is synchronous and passes a three-flop chain.
*/
`timescale 1ns/10ps
`include "afu_consts.svh"

module afu_top
(
    input  logic                   pClk,
    input  logic                   reset,

    // MMIO requests from the host
    input  logic                   rx_mmio_wr,
    input  logic                   rx_mmio_rd,
    input  logic [`AFU_ADDR_W-1:0] rx_mmio_addr,
    input  logic [`AFU_TID_W-1:0]  rx_mmio_tid,
    input  logic [`AFU_DATA_W-1:0] rx_mmio_data,

    // Read responses to the host
    output logic                   tx_rsp_valid,
    output logic [`AFU_TID_W-1:0]  tx_rsp_tid,
    output logic [`AFU_DATA_W-1:0] tx_rsp_data
);

    // ==================================================
    // Edge to register file link
    // ==================================================
    mmio_if mmio();

    // Shell edge, retiming and reset sync
    ccip_edge u_edge
    (
        .pClk         (pClk),
        .reset        (reset),
        .rx_mmio_wr   (rx_mmio_wr),
        .rx_mmio_rd   (rx_mmio_rd),
        .rx_mmio_addr (rx_mmio_addr),
        .rx_mmio_tid  (rx_mmio_tid),
        .rx_mmio_data (rx_mmio_data),
        .tx_rsp_valid (tx_rsp_valid),
        .tx_rsp_tid   (tx_rsp_tid),
        .tx_rsp_data  (tx_rsp_data),
        .mmio         (mmio.edge_side)
    );

    // User model
    mmio_csr_file u_csr_file
    (
        .pClk (pClk),
        .mmio (mmio.csr)
    );

endmodule

// ==== tb/tb_clock.sv ====
/*
  Clock and reset source for the testbench. pClk runs with an 8 ns period.
  Reset is high from time zero and drops on the 8th rising edge.
*/
`timescale 1ns/10ps

module tb_clock
(
    output logic pClk,
    output logic reset
);

    // Free running clock, 4 ns per phase
    initial
    begin
        pClk = 1'b0;
        forever #4 pClk = ~pClk;
    end

    // Reset changes on a rising edge like any other input
    initial
    begin
        reset <= 1'b1;
        repeat (8) @(posedge pClk);
        reset <= 1'b0;
    end

endmodule

// ==== tb/tb_checker.sv ====
/*
  Response checker. Every read pushed here must come back on the DUT outputs
  three edges after the DUT samples it, in push order and with its own tag.
*/
`timescale 1ns/10ps
`include "afu_consts.svh"

module tb_checker
(
    input  logic                   pClk,
    // Expected read, seen in the same cycle the DUT samples the request
    input  logic                   exp_push,
    input  logic [`AFU_TID_W-1:0]  exp_tid,
    input  logic [`AFU_DATA_W-1:0] exp_data,
    // DUT response outputs
    input  logic                   tx_rsp_valid,
    input  logic [`AFU_TID_W-1:0]  tx_rsp_tid,
    input  logic [`AFU_DATA_W-1:0] tx_rsp_data,
    output int                     mismatch_count,
    output int                     other_count,
    output int                     outstanding
);

    // Pending reads, oldest first
    logic [`AFU_TID_W-1:0]  q_tid[$];
    logic [`AFU_DATA_W-1:0] q_data[$];
    int                     q_due[$];
    int                     cycle = 0;
    int                     n_mismatch = 0;
    int                     n_other = 0;
    int                     n_pending = 0;

    assign mismatch_count = n_mismatch;
    assign other_count    = n_other;
    assign outstanding    = n_pending;

    always @(posedge pClk)
    begin : check_rsp
        logic [`AFU_TID_W-1:0]  tid;
        logic [`AFU_DATA_W-1:0] data;
        int                     due;
        cycle = cycle + 1;
        if (tx_rsp_valid)
        begin
            if (q_tid.size() == 0)
            begin
                $display("ERROR: response with tag %h at cycle %0d has no read pending",
                         tx_rsp_tid, cycle);
                n_other = n_other + 1;
            end
            else
            begin
                tid  = q_tid.pop_front();
                data = q_data.pop_front();
                due  = q_due.pop_front();
                if (tx_rsp_tid !== tid)
                begin
                    $display("MISMATCH tx_rsp_tid: got %h expected %h", tx_rsp_tid, tid);
                    n_mismatch = n_mismatch + 1;
                end
                if (tx_rsp_data !== data)
                begin
                    $display("MISMATCH tx_rsp_data (tag %h): got %h expected %h",
                             tid, tx_rsp_data, data);
                    n_mismatch = n_mismatch + 1;
                end
                if (cycle != due)
                begin
                    $display("ERROR: response for tag %h came at cycle %0d instead of %0d",
                             tid, cycle, due);
                    n_other = n_other + 1;
                end
            end
        end
        // Input register, register file and output register, one edge each
        if (exp_push)
        begin
            q_tid.push_back(exp_tid);
            q_data.push_back(exp_data);
            q_due.push_back(cycle + 3);
        end
        n_pending = q_tid.size();
    end

endmodule

// ==== tb/tb_afu_top.sv ====
/*
  Testbench for afu_top. A table of MMIO writes and reads is built at time
  zero along with the expected read data, then driven one entry per clock.
  Addresses and identifiers come from afu_consts.svh.
*/
`timescale 1ns/10ps
`include "afu_consts.svh"

module tb_afu_top;

    localparam int MAX_ENTRIES = 80;
    // Entry kinds
    localparam int KIND_IDLE = 0;
    localparam int KIND_WR   = 1;
    localparam int KIND_RD   = 2;

    logic                   pClk;
    logic                   reset;
    logic                   rx_mmio_wr;
    logic                   rx_mmio_rd;
    logic [`AFU_ADDR_W-1:0] rx_mmio_addr;
    logic [`AFU_TID_W-1:0]  rx_mmio_tid;
    logic [`AFU_DATA_W-1:0] rx_mmio_data;
    logic                   tx_rsp_valid;
    logic [`AFU_TID_W-1:0]  tx_rsp_tid;
    logic [`AFU_DATA_W-1:0] tx_rsp_data;
    logic                   exp_push;
    logic [`AFU_TID_W-1:0]  exp_tid;
    logic [`AFU_DATA_W-1:0] exp_data;
    int                     mismatch_count;
    int                     other_count;
    int                     outstanding;

    tb_clock   u_clock (.*);
    afu_top    u_afu_top (.*);
    tb_checker u_checker (.*);

    // ==================================================
    // Stimulus table and reference model
    // ==================================================
    int                     kind_tbl [MAX_ENTRIES];
    logic [`AFU_ADDR_W-1:0] addr_tbl [MAX_ENTRIES];
    logic [`AFU_DATA_W-1:0] data_tbl [MAX_ENTRIES];
    logic [`AFU_TID_W-1:0]  tid_tbl  [MAX_ENTRIES];
    logic [`AFU_DATA_W-1:0] exp_tbl  [MAX_ENTRIES];
    int                     n_entries = 0;
    int                     timeout_limit = 0;
    int                     cycle_count = 0;
    logic [31:0]            lfsr_state = 32'hcc08_5571;
    logic [`AFU_TID_W-1:0]  next_tid = 9'h0f0;

    // Register contents as the host should see them
    logic [`AFU_DATA_W-1:0] m_scratch0 = '0;
    logic [`AFU_DATA_W-1:0] m_scratch1 = '0;
    logic [`AFU_DATA_W-1:0] m_result = '0;
    logic [`AFU_DATA_W-1:0] m_count = '0;
    logic [1:0]             m_cmd = 2'd0;
    // Command result not yet visible to reads
    logic                   m_pend = 1'b0;
    logic [`AFU_DATA_W-1:0] m_pend_value = '0;
    int                     m_pend_idx = 0;

    // Galois form, one shift per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic random_word(output logic [`AFU_DATA_W-1:0] v);
        for (int b = 0; b < `AFU_DATA_W; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v[b] = lfsr_state[0];
        end
    endtask

    // Wrapped 64-bit result of an opcode
    function automatic logic [`AFU_DATA_W-1:0] expect_op(input logic [1:0] op,
        input logic [`AFU_DATA_W-1:0] a, input logic [`AFU_DATA_W-1:0] b);
        case (op)
            afu_pkg::OP_ADD: return a + b;
            afu_pkg::OP_SUB: return a - b;
            default:         return a ^ b;
        endcase
    endfunction

    task automatic add_entry(input int kind, input logic [`AFU_ADDR_W-1:0] addr,
                             input logic [`AFU_DATA_W-1:0] data);
        int                     i;
        logic [`AFU_DATA_W-1:0] exp;
        i   = n_entries;
        exp = '0;
        // RESULT and STATUS move two entries after the CMD write
        if (m_pend && i >= m_pend_idx + 2)
        begin
            m_result = m_pend_value;
            m_count  = m_count + 1;
            m_pend   = 1'b0;
        end
        if (kind == KIND_RD)
        begin
            case (addr)
                `CSR_ID_L:     exp = `AFU_ID_L;
                `CSR_ID_H:     exp = `AFU_ID_H;
                `CSR_SCRATCH0: exp = m_scratch0;
                `CSR_SCRATCH1: exp = m_scratch1;
                `CSR_CMD:      exp = {62'd0, m_cmd};
                `CSR_RESULT:   exp = m_result;
                `CSR_STATUS:   exp = m_count;
                default:       exp = '0;
            endcase
        end
        // Writes show on reads from the next entry on
        if (kind == KIND_WR)
        begin
            case (addr)
                `CSR_SCRATCH0: m_scratch0 = data;
                `CSR_SCRATCH1: m_scratch1 = data;
                `CSR_CMD:
                begin
                    m_cmd = data[1:0];
                    if (m_cmd != afu_pkg::OP_NOP)
                    begin
                        m_pend       = 1'b1;
                        m_pend_value = expect_op(m_cmd, m_scratch0, m_scratch1);
                        m_pend_idx   = i;
                    end
                end
                // Read-only and unmapped words keep their value
                default: ;
            endcase
        end
        kind_tbl[i] = kind;
        addr_tbl[i] = addr;
        data_tbl[i] = data;
        tid_tbl[i]  = next_tid;
        exp_tbl[i]  = exp;
        if (kind == KIND_RD)
            next_tid = next_tid + 1'b1;
        n_entries = i + 1;
    endtask

    task automatic build_table();
        logic [`AFU_DATA_W-1:0] v;
        // Values right after reset
        add_entry(KIND_RD, `CSR_ID_L, '0);
        add_entry(KIND_RD, `CSR_ID_H, '0);
        add_entry(KIND_RD, `CSR_SCRATCH0, '0);
        add_entry(KIND_RD, `CSR_SCRATCH1, '0);
        add_entry(KIND_RD, `CSR_CMD, '0);
        add_entry(KIND_RD, `CSR_RESULT, '0);
        add_entry(KIND_RD, `CSR_STATUS, '0);
        add_entry(KIND_IDLE, '0, '0);
        // Scratch readback, reads back to back
        random_word(v);
        add_entry(KIND_WR, `CSR_SCRATCH0, v);
        random_word(v);
        add_entry(KIND_WR, `CSR_SCRATCH1, v);
        add_entry(KIND_RD, `CSR_SCRATCH0, '0);
        add_entry(KIND_RD, `CSR_SCRATCH1, '0);
        add_entry(KIND_RD, `CSR_SCRATCH0, '0);
        // ADD, SUB and XOR twice each with fresh operands
        for (int r = 0; r < 6; r++)
        begin
            random_word(v);
            add_entry(KIND_WR, `CSR_SCRATCH0, v);
            random_word(v);
            add_entry(KIND_WR, `CSR_SCRATCH1, v);
            random_word(v);
            // Upper command bits are junk on purpose
            add_entry(KIND_WR, `CSR_CMD, {v[63:2], 2'(r % 3 + 1)});
            // One entry later STATUS still holds the old count
            add_entry(KIND_RD, `CSR_STATUS, '0);
            add_entry(KIND_RD, `CSR_RESULT, '0);
            add_entry(KIND_RD, `CSR_STATUS, '0);
        end
        // NOP keeps RESULT and STATUS
        random_word(v);
        add_entry(KIND_WR, `CSR_CMD, {v[63:2], 2'b00});
        add_entry(KIND_IDLE, '0, '0);
        add_entry(KIND_RD, `CSR_RESULT, '0);
        add_entry(KIND_RD, `CSR_STATUS, '0);
        add_entry(KIND_RD, `CSR_CMD, '0);
        // Holes in the map and read-only words
        add_entry(KIND_RD, 16'h0020, '0);
        add_entry(KIND_RD, 16'h0003, '0);
        random_word(v);
        add_entry(KIND_WR, `CSR_ID_L, v);
        add_entry(KIND_WR, 16'h0020, v);
        add_entry(KIND_WR, `CSR_RESULT, v);
        add_entry(KIND_RD, `CSR_ID_L, '0);
        add_entry(KIND_RD, 16'h0020, '0);
        add_entry(KIND_RD, `CSR_RESULT, '0);
    endtask

    // ==================================================
    // Drive loop and final report
    // ==================================================
    initial
    begin
        rx_mmio_wr   <= 1'b0;
        rx_mmio_rd   <= 1'b0;
        rx_mmio_addr <= '0;
        rx_mmio_tid  <= '0;
        rx_mmio_data <= '0;
        exp_push     <= 1'b0;
        exp_tid      <= '0;
        exp_data     <= '0;
        build_table();
        timeout_limit = n_entries + 50;
        @(negedge reset);
        repeat (6) @(posedge pClk);
        for (int i = 0; i < n_entries; i++)
        begin
            rx_mmio_wr   <= (kind_tbl[i] == KIND_WR);
            rx_mmio_rd   <= (kind_tbl[i] == KIND_RD);
            rx_mmio_addr <= addr_tbl[i];
            rx_mmio_tid  <= tid_tbl[i];
            rx_mmio_data <= data_tbl[i];
            exp_push     <= (kind_tbl[i] == KIND_RD);
            exp_tid      <= tid_tbl[i];
            exp_data     <= exp_tbl[i];
            @(posedge pClk);
        end
        rx_mmio_wr <= 1'b0;
        rx_mmio_rd <= 1'b0;
        exp_push   <= 1'b0;
        @(posedge pClk);
        wait (outstanding == 0);
        // A few idle cycles to catch stray responses
        repeat (4) @(posedge pClk);
        $display("Run finished after %0d cycles: %0d mismatches, %0d other errors",
                 cycle_count, mismatch_count, other_count);
        if (mismatch_count + other_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog
    always @(posedge pClk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("Timeout after %0d cycles with %0d reads still unanswered",
                     cycle_count, outstanding);
            $display("Run finished after %0d cycles: %0d mismatches, %0d other errors",
                     cycle_count, mismatch_count, other_count + 1);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+include
source/afu_pkg.sv
source/mmio_if.sv
source/csr_op_unit.sv
source/ccip_edge.sv
source/mmio_csr_file.sv
source/afu_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_afu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --assert --top-module tb_afu_top -f filelist.f -o tb_afu_top \
    && ./obj_dir/tb_afu_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "No pass line in the log"; exit 1; }
echo "Simulation passed"
